//--- carrd.f
hw/v_isa_pkg.sv
hw/v_arch_pkg.sv
hw/v_decoder.sv
hw/v_regfile.sv
hw/v_lane_alu.sv
hw/v_sequencer.sv
hw/carrd_integrated.sv
test/carrd_checker.sv
test/carrd_tb.sv

//--- test/carrd_tb.sv
`timescale 1ns/1ns

module carrd_tb;

    import v_isa_pkg::*;
    import v_arch_pkg::*;

    localparam int NW = 4;
    localparam int ACK_LIMIT = 40;   // edges per wait

    logic             clk, reset, instr_req, instr_ack, dm_v_write;
    word_t            instr, xreg_out1;
    xreg_addr_t       v_rd_xreg_addr1;
    mem_addr_t        data_addr;
    logic [NW*32-1:0] v_store_data;
    word_t            xregs [32];   // base core scalar registers
    int               own_errors, chk_errors, checks, tests_run, tests_failed, base_err;

    assign xreg_out1 = xregs[v_rd_xreg_addr1];   // read port answers same cycle

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    carrd_integrated #(.num_words(NW)) DUT (
        .clk(clk), .reset(reset), .instr(instr), .instr_req(instr_req),
        .instr_ack(instr_ack), .v_rd_xreg_addr1(v_rd_xreg_addr1), .xreg_out1(xreg_out1),
        .dm_v_write(dm_v_write), .data_addr(data_addr), .v_store_data(v_store_data)
    );

    carrd_checker #(.num_words(NW)) u_checker (
        .clk(clk), .reset(reset), .instr(instr), .instr_req(instr_req),
        .instr_ack(instr_ack), .v_rd_xreg_addr1(v_rd_xreg_addr1), .xreg_out1(xreg_out1),
        .dm_v_write(dm_v_write), .data_addr(data_addr), .v_store_data(v_store_data),
        .error_count(chk_errors), .check_count(checks)
    );

    //////////////////////////////////////////////////
    // instruction encoders
    //////////////////////////////////////////////////

    function automatic word_t cfg_word(input logic [2:0] sew_code);
        return {1'b0, 5'd0, sew_code, 3'b000, 5'd0, OPCFG, 5'd0, OP_V};   // lmul 1
    endfunction

    function automatic word_t op_word(input logic [5:0] f6, input logic [2:0] f3,
            input logic [4:0] vd, input logic [4:0] vs2, input logic [4:0] src);
        return {f6, 1'b1, vs2, src, f3, vd, OP_V};   // unmasked
    endfunction

    function automatic word_t store_word(input logic [4:0] vs3, input logic [4:0] rs1);
        return {7'b0000001, 5'd0, rs1, ST_W32, vs3, STORE_FP};   // unit stride
    endfunction

    task automatic finish_run();
        int total;
        total = own_errors + chk_errors;
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, total);
        if (total == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    endtask

    task automatic abort_on_timeout(input string what);
        $display("timeout: %s", what);
        own_errors++;
        finish_run();
    endtask

    task automatic expect_low(input string name, input logic value);
        if (value !== 1'b0) begin
            $display("ERROR %s: got 0x%h expected 0x0", name, value);
            own_errors++;
        end
    endtask

    task automatic set_xreg(input int idx, input word_t value);
        @(posedge clk);
        if (idx != 0)
            xregs[idx] <= value;   // x0 stays zero
    endtask

    // one four-phase transaction with req held extra_hold edges past ack
    task automatic run_instr(input word_t ins, input int extra_hold);
        int waited;
        @(posedge clk);
        if (instr_ack !== 1'b0) begin
            $display("ack still high before a new request");
            own_errors++;
        end
        instr     <= ins;
        instr_req <= 1'b1;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
            if (waited > ACK_LIMIT)
                abort_on_timeout("no ack after request");
        end while (instr_ack !== 1'b1);
        if (waited != 5) begin   // ack high three edges after req is sampled and read one late
            $display("ack seen %0d edges after req, expected 5", waited);
            own_errors++;
        end
        repeat (extra_hold) begin
            @(posedge clk);
            if (instr_ack !== 1'b1) begin
                $display("ack fell while req was still held");
                own_errors++;
            end
        end
        instr_req <= 1'b0;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
            if (waited > ACK_LIMIT)
                abort_on_timeout("ack stuck high after req dropped");
        end while (instr_ack !== 1'b0);
        if (waited != 2) begin
            $display("ack fell %0d edges after req dropped, expected 2", waited);
            own_errors++;
        end
    endtask

    task automatic end_test(input string name);
        int now_err;
        now_err = own_errors + chk_errors;
        tests_run++;
        if (now_err == base_err) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_run, name, now_err - base_err);
        end
        base_err = now_err;
    endtask

    //////////////////////////////////////////////////
    // test list
    //////////////////////////////////////////////////

    initial begin
        logic [5:0] logic_ops [3];
        logic [5:0] all_ops [6];
        logic [2:0] forms [3];
        logic [5:0] f6;
        logic [2:0] f3;
        word_t      ins;
        logic_ops = '{F6_VAND, F6_VOR, F6_VXOR};
        all_ops   = '{F6_VADD, F6_VSUB, F6_VAND, F6_VOR, F6_VXOR, F6_VMV};
        forms     = '{OPIVV, OPIVX, OPIVI};
        void'($urandom(32'h4105_3754));
        reset     = 1'b1;
        instr_req = 1'b0;
        instr     = '0;
        for (int k = 0; k < 32; k++)
            xregs[k] = '0;

        // quiet through reset and until the first req
        for (int k = 0; k < 16; k++) begin
            @(posedge clk);
            if (k > 0) begin
                expect_low("instr_ack", instr_ack);
                expect_low("dm_v_write", dm_v_write);
            end
        end
        reset <= 1'b0;
        repeat (6) begin
            @(posedge clk);
            expect_low("instr_ack", instr_ack);
            expect_low("dm_v_write", dm_v_write);
        end
        end_test("reset");

        // splats at each sew with a store after each
        for (int s = 0; s < 3; s++) begin
            set_xreg(5, $urandom);
            set_xreg(10, $urandom);
            set_xreg(11, $urandom);
            run_instr(cfg_word(3'(s)), 0);
            run_instr(op_word(F6_VMV, OPIVX, 5'd1, 5'd0, 5'd5), 0);
            run_instr(store_word(5'd1, 5'd10), 0);
            run_instr(op_word(F6_VMV, OPIVI, 5'd2, 5'd0, 5'($urandom)), 0);
            run_instr(store_word(5'd2, 5'd11), 0);
        end
        end_test("vmv splat and store");

        // vv add and sub on operands built at e32 so elements differ
        for (int s = 0; s < 3; s++) begin
            set_xreg(6, $urandom);
            set_xreg(7, $urandom);
            run_instr(cfg_word(3'd2), 0);
            run_instr(op_word(F6_VMV, OPIVX, 5'd4, 5'd0, 5'd6), 0);
            run_instr(op_word(F6_VMV, OPIVX, 5'd5, 5'd0, 5'd7), 0);
            run_instr(cfg_word(3'(s)), 0);
            run_instr(op_word(F6_VADD, OPIVV, 5'd6, 5'd5, 5'd4), 0);
            run_instr(op_word(F6_VSUB, OPIVV, 5'd7, 5'd5, 5'd4), 0);
            run_instr(store_word(5'd6, 5'd10), 0);
            run_instr(store_word(5'd7, 5'd11), 0);
        end
        end_test("vadd vsub vv");

        // logic ops in vx and vi forms
        for (int s = 0; s < 3; s++) begin
            set_xreg(8, $urandom);
            run_instr(cfg_word(3'(s)), 0);
            for (int k = 0; k < 3; k++) begin
                run_instr(op_word(logic_ops[k], OPIVX, 5'd8, 5'd6, 5'd8), 0);
                run_instr(op_word(logic_ops[k], OPIVI, 5'd9, 5'd7, 5'($urandom)), 0);
                run_instr(store_word(5'd8, 5'd10), 0);
                run_instr(store_word(5'd9, 5'd11), 0);
            end
        end
        end_test("vand vor vxor vx vi");

        // held req runs once and unsupported encodings change nothing
        run_instr(op_word(F6_VMV, OPIVX, 5'd3, 5'd0, 5'd5), 0);
        run_instr(op_word(F6_VADD, OPIVV, 5'd3, 5'd3, 5'd3), 6);   // doubles v3 once
        run_instr(store_word(5'd3, 5'd10), 5);
        run_instr(op_word(6'b111111, OPIVV, 5'd3, 5'd4, 5'd4), 0);
        run_instr(op_word(F6_VSUB, OPIVI, 5'd3, 5'd3, 5'd7), 0);   // no vsub.vi
        run_instr(cfg_word(3'd0), 0);                              // e8 so a taken e64 shows
        run_instr(cfg_word(3'd3), 0);                              // e64 rejected
        run_instr(store_word(5'd3, 5'd11), 0);
        run_instr(op_word(F6_VADD, OPIVX, 5'd11, 5'd3, 5'd5), 0);
        run_instr(store_word(5'd11, 5'd10), 0);
        end_test("handshake and unsupported");

        // random sequence after every register is seeded
        run_instr(cfg_word(3'd2), 0);
        for (int r = 1; r < 32; r++)
            set_xreg(r, $urandom);
        for (int r = 0; r < 32; r++)
            run_instr(op_word(F6_VMV, OPIVX, 5'(r), 5'd0, 5'(r % 31 + 1)), 0);
        for (int n = 0; n < 200; n++) begin
            if (n % 8 == 7) begin
                ins = store_word(5'($urandom), 5'($urandom));
            end else if ($urandom_range(0, 9) == 0) begin
                ins = cfg_word(3'($urandom_range(0, 2)));
            end else begin
                f6 = all_ops[$urandom_range(0, 5)];
                f3 = forms[$urandom_range(0, 2)];
                if (f6 == F6_VSUB && f3 == OPIVI)
                    f3 = OPIVX;
                if (f6 == F6_VMV && f3 == OPIVV)
                    f3 = OPIVI;
                ins = op_word(f6, f3, 5'($urandom), (f6 == F6_VMV) ? 5'd0 : 5'($urandom),
                              5'($urandom));
            end
            run_instr(ins, 0);
        end
        end_test("random sequence");

        finish_run();
    end

endmodule

//--- test/carrd_checker.sv
`timescale 1ns/1ns

module carrd_checker #(
    parameter int num_words = 4
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [31:0]             instr,
    input  logic                    instr_req,
    input  logic                    instr_ack,
    input  logic [4:0]              v_rd_xreg_addr1,
    input  logic [31:0]             xreg_out1,
    input  logic                    dm_v_write,
    input  logic [15:0]             data_addr,
    input  logic [num_words*32-1:0] v_store_data,
    output int                      error_count,
    output int                      check_count
);

    import v_isa_pkg::*;

    localparam int VBITS = num_words * 32;
    localparam int K_NOP = 0;
    localparam int K_CFG = 1;
    localparam int K_ALU = 2;
    localparam int K_STORE = 3;

    logic [VBITS-1:0] vregs [32];   // model register file
    logic [2:0]       sew_m;        // model vtype.vsew
    logic [31:0]      pend;         // instruction in flight
    logic             busy, stored, ack_q;
    int               wait_cycles;

    // which class of the kept subset an encoding falls into
    function automatic int classify(input logic [31:0] ins);
        logic [2:0] f3;
        logic [5:0] f6;
        f3 = ins[14:12];
        f6 = ins[31:26];
        if (ins[6:0] == STORE_FP) begin
            if ((ins[31:20] == {7'b0000001, 5'b00000}) && (f3 inside {ST_W8, ST_W16, ST_W32}))
                return K_STORE;
            return K_NOP;
        end
        if (ins[6:0] != OP_V)
            return K_NOP;
        if (f3 == OPCFG)
            return (!ins[31] && ins[25:23] <= 3'd2) ? K_CFG : K_NOP;   // e8..e32 only
        if (!ins[25] || !(f3 inside {OPIVV, OPIVX, OPIVI}))
            return K_NOP;                                            // masked or other funct3
        if (f6 inside {F6_VADD, F6_VAND, F6_VOR, F6_VXOR})
            return K_ALU;
        if (f6 == F6_VSUB)
            return (f3 != OPIVI) ? K_ALU : K_NOP;
        if (f6 == F6_VMV)
            return (f3 != OPIVV && ins[24:20] == 5'd0) ? K_ALU : K_NOP;
        return K_NOP;
    endfunction

    //////////////////////////////////////////////////
    // reference function, element by element
    //////////////////////////////////////////////////

    function automatic logic [VBITS-1:0] ref_alu(input logic [31:0] ins,
            input logic [VBITS-1:0] va, input logic [VBITS-1:0] vb,
            input logic [31:0] scalar, input logic [2:0] sew_code);
        int               ew;
        logic [31:0]      mask, a, b, r;
        logic [VBITS-1:0] elem, out;
        ew   = 8 << sew_code;                               // element width in bits
        mask = (ew == 32) ? 32'hffff_ffff : (32'd1 << ew) - 32'd1;
        out  = '0;
        for (int n = 0; n < VBITS / ew; n++) begin
            b = 32'(vb >> (n * ew)) & mask;                 // vs2 element
            case (ins[14:12])
                OPIVV:   a = 32'(va >> (n * ew)) & mask;
                OPIVX:   a = scalar & mask;                 // scalar cut to sew
                default: a = 32'(ins[19:15]);               // zero-extended imm
            endcase
            case (ins[31:26])
                F6_VADD: r = b + a;
                F6_VSUB: r = b - a;
                F6_VAND: r = b & a;
                F6_VOR:  r = b | a;
                F6_VXOR: r = b ^ a;
                default: r = a;                             // splat
            endcase
            elem = VBITS'(r & mask);                        // wraps mod 2^sew
            out  = out | (elem << (n * ew));
        end
        return out;
    endfunction

    task automatic check_hex(input string name, input logic [31:0] got, input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            $display("ERROR %s: got 0x%h expected 0x%h (instr 0x%h)", name, got, exp, pend);
            error_count++;
        end
    endtask

    task automatic report(input string what);
        $display("checker: %s, instr 0x%h", what, pend);
        error_count++;
    endtask

    initial begin
        error_count = 0;
        check_count = 0;
    end

    //////////////////////////////////////////////////
    // follow transactions on the port
    //////////////////////////////////////////////////

    always @(posedge clk) begin
        if (reset) begin
            sew_m = 3'd2;     // e32 out of reset
            busy  = 1'b0;
            ack_q = 1'b0;
        end else begin
            if (instr_req && !instr_ack && !busy) begin
                pend        = instr;     // DUT latches on the same edge
                busy        = 1'b1;
                stored      = 1'b0;
                wait_cycles = 0;
            end
            if (dm_v_write) begin
                if (!busy || stored || classify(pend) != K_STORE) begin
                    report("store pulse with no store instruction pending");
                end else begin
                    stored = 1'b1;
                    check_hex("data_addr", data_addr, 32'(xreg_out1[15:0]));
                    for (int i = 0; i < num_words; i++)
                        check_hex($sformatf("v_store_data[%0d]", i), v_store_data[32*i +: 32],
                                  vregs[pend[11:7]][32*i +: 32]);   // word i, vs3
                end
            end
            if (instr_ack && !ack_q) begin
                if (!busy) begin
                    report("ack raised with no request pending");
                end else begin
                    check_hex("v_rd_xreg_addr1", 32'(v_rd_xreg_addr1), 32'(pend[19:15]));
                    case (classify(pend))
                        K_CFG:   sew_m = pend[25:23];
                        K_ALU:   vregs[pend[11:7]] = ref_alu(pend, vregs[pend[19:15]],
                                     vregs[pend[24:20]], xreg_out1, sew_m);
                        K_STORE: if (!stored) report("store retired without a store pulse");
                        default: ;   // unsupported, no effect
                    endcase
                    busy = 1'b0;
                end
            end
            if (busy) begin
                wait_cycles++;
                if (wait_cycles == 40)
                    report("no ack within 40 cycles of the request");
            end
            ack_q = instr_ack;
        end
    end

endmodule

//--- hw/carrd_integrated.sv
`timescale 1ns/1ns

module carrd_integrated #(
    parameter int num_words = 4                   // 32-bit words per vector register
) (
    input  logic                       clk,
    input  logic                       reset,
    input  v_arch_pkg::word_t          instr,     // from the base processor
    input  logic                       instr_req,
    output logic                       instr_ack,
    output v_isa_pkg::xreg_addr_t      v_rd_xreg_addr1,
    input  v_arch_pkg::word_t          xreg_out1, // scalar rs1 value, same cycle
    output logic                       dm_v_write,
    output v_arch_pkg::mem_addr_t      data_addr,
    output logic [num_words*32-1:0]    v_store_data
);

    import v_isa_pkg::*;
    import v_arch_pkg::*;

    // decoder outputs
    word_t      latched_instr;
    logic       is_vconfig, is_vstore, is_valu;
    valu_op_e   alu_op;
    src_sel_e   src_a;
    vreg_addr_t vd, vs1, vs2;
    xreg_addr_t rs1;
    imm5_t      imm;
    sew_e       new_sew;

    // register file and lanes
    vreg_addr_t              rd_addr_a, rd_addr_b, wr_addr;
    logic [num_words*32-1:0] rd_data_a, rd_data_b, wr_data;
    logic                    wr_en;
    valu_op_e                lane_op;
    sew_e                    sew;
    logic [num_words*32-1:0] lane_a, lane_b, lane_result;

    v_decoder u_decoder (
        .instr(latched_instr), .is_vconfig(is_vconfig), .is_vstore(is_vstore),
        .is_valu(is_valu), .alu_op(alu_op), .src_a(src_a), .vd(vd), .vs1(vs1),
        .vs2(vs2), .rs1(rs1), .imm(imm), .new_sew(new_sew)
    );

    v_sequencer #(.num_words(num_words)) u_sequencer (
        .clk(clk), .reset(reset), .instr(instr), .instr_req(instr_req),
        .instr_ack(instr_ack), .xreg_out1(xreg_out1), .v_rd_xreg_addr1(v_rd_xreg_addr1),
        .latched_instr(latched_instr), .is_vconfig(is_vconfig), .is_vstore(is_vstore),
        .is_valu(is_valu), .alu_op(alu_op), .src_a(src_a), .vd(vd), .vs1(vs1),
        .vs2(vs2), .rs1(rs1), .imm(imm), .new_sew(new_sew),
        .rd_addr_a(rd_addr_a), .rd_addr_b(rd_addr_b), .rd_data_a(rd_data_a),
        .rd_data_b(rd_data_b), .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
        .lane_op(lane_op), .sew(sew), .lane_a(lane_a), .lane_b(lane_b),
        .lane_result(lane_result), .dm_v_write(dm_v_write), .data_addr(data_addr),
        .v_store_data(v_store_data)
    );

    v_regfile #(.num_words(num_words)) u_regfile (
        .clk(clk), .rd_addr_a(rd_addr_a), .rd_addr_b(rd_addr_b), .wr_en(wr_en),
        .wr_addr(wr_addr), .wr_data(wr_data), .rd_data_a(rd_data_a), .rd_data_b(rd_data_b)
    );

    // one lane per 32-bit word of the register
    for (genvar i = 0; i < num_words; i++) begin : g_lane
        v_lane_alu u_lane (
            .op(lane_op),
            .sew(sew),
            .op_a(lane_a[32*i +: 32]),
            .op_b(lane_b[32*i +: 32]),
            .result(lane_result[32*i +: 32])
        );
    end

endmodule

//--- hw/v_sequencer.sv
`timescale 1ns/1ns

module v_sequencer #(
    parameter int num_words = 4
) (
    input  logic                    clk,
    input  logic                    reset,
    // host side
    input  v_arch_pkg::word_t       instr,
    input  logic                    instr_req,
    output logic                    instr_ack,
    input  v_arch_pkg::word_t       xreg_out1,
    output v_isa_pkg::xreg_addr_t   v_rd_xreg_addr1,
    // decoder
    output v_arch_pkg::word_t       latched_instr,
    input  logic                    is_vconfig,
    input  logic                    is_vstore,
    input  logic                    is_valu,
    input  v_isa_pkg::valu_op_e     alu_op,
    input  v_isa_pkg::src_sel_e     src_a,
    input  v_isa_pkg::vreg_addr_t   vd,
    input  v_isa_pkg::vreg_addr_t   vs1,
    input  v_isa_pkg::vreg_addr_t   vs2,
    input  v_isa_pkg::xreg_addr_t   rs1,
    input  v_isa_pkg::imm5_t        imm,
    input  v_arch_pkg::sew_e        new_sew,
    // register file
    output v_isa_pkg::vreg_addr_t   rd_addr_a,
    output v_isa_pkg::vreg_addr_t   rd_addr_b,
    input  logic [num_words*32-1:0] rd_data_a,
    input  logic [num_words*32-1:0] rd_data_b,
    output logic                    wr_en,
    output v_isa_pkg::vreg_addr_t   wr_addr,
    output logic [num_words*32-1:0] wr_data,
    // lanes
    output v_isa_pkg::valu_op_e     lane_op,
    output v_arch_pkg::sew_e        sew,        // vtype.vsew
    output logic [num_words*32-1:0] lane_a,
    output logic [num_words*32-1:0] lane_b,
    input  logic [num_words*32-1:0] lane_result,
    // data memory store port
    output logic                    dm_v_write,
    output v_arch_pkg::mem_addr_t   data_addr,
    output logic [num_words*32-1:0] v_store_data
);

    import v_isa_pkg::*;
    import v_arch_pkg::*;

    typedef enum logic [2:0] {IDLE, DECODE, EXEC, WRITE, HOLD_ACK} state_e;

    state_e                  state;
    logic [num_words*32-1:0] result_q;      // lane outputs captured in EXEC
    word_t                   a_word;        // broadcast scalar or immediate

    // replicate the low SEW bits across one lane word
    function automatic word_t splat(word_t value, sew_e width);
        case (width)
            E8:      return {4{value[7:0]}};
            E16:     return {2{value[15:0]}};
            default: return value;
        endcase
    endfunction

    ////////////////////////////////////////////////////
    // handshake FSM and vtype
    ////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
            sew   <= E32;
        end else begin
            case (state)
                IDLE:     if (instr_req) state <= DECODE;
                DECODE:   state <= EXEC;      // decoder settles on latched_instr
                EXEC:     state <= WRITE;
                WRITE: begin
                    state <= HOLD_ACK;
                    if (is_vconfig) begin
                        sew <= new_sew;
                    end
                end
                HOLD_ACK: if (!instr_req) state <= IDLE;
                default:  state <= IDLE;
            endcase
        end
    end

    // instruction latch, result and store address
    always_ff @(posedge clk) begin
        if (state == IDLE && instr_req) begin
            latched_instr <= instr;
        end
        if (state == EXEC) begin
            result_q  <= lane_result;
            data_addr <= xreg_out1[DATAMEM_BITS-1:0];  // store base from rs1
        end
    end

    ////////////////////////////////////////////////////
    // operand selection
    ////////////////////////////////////////////////////

    assign v_rd_xreg_addr1 = rs1;
    assign rd_addr_a       = vs1;     // vs3 for a store
    assign rd_addr_b       = vs2;

    always_comb begin
        case (src_a)
            SRC_SCALAR: a_word = splat(xreg_out1, sew);       // truncated to SEW
            SRC_IMM:    a_word = splat(word_t'(imm), sew);    // zero-extended
            default:    a_word = '0;
        endcase
    end

    assign lane_a  = (src_a == SRC_VREG) ? rd_data_a : {num_words{a_word}};
    assign lane_b  = rd_data_b;
    assign lane_op = alu_op;

    ////////////////////////////////////////////////////
    // commit
    ////////////////////////////////////////////////////

    assign wr_en        = (state == WRITE) && is_valu;
    assign wr_addr      = vd;
    assign wr_data      = result_q;
    assign dm_v_write   = (state == WRITE) && is_vstore;   // one cycle only
    assign v_store_data = result_q;                        // word i to data_addr + i
    assign instr_ack    = (state == HOLD_ACK);

endmodule

//--- hw/v_lane_alu.sv
`timescale 1ns/1ns

module v_lane_alu (
    input  v_isa_pkg::valu_op_e op,
    input  v_arch_pkg::sew_e    sew,
    input  v_arch_pkg::word_t   op_a,     // vs1, scalar or immediate
    input  v_arch_pkg::word_t   op_b,     // vs2
    output v_arch_pkg::word_t   result
);

    import v_isa_pkg::*;
    import v_arch_pkg::*;

    logic [3:0] elem_start;     // byte i begins a new element
    word_t      a_in;
    word_t      sum;

    always_comb begin
        case (sew)
            E8:      elem_start = 4'b1111;
            E16:     elem_start = 4'b0101;
            default: elem_start = 4'b0001;
        endcase
    end

    // vsub is vs2 minus operand a, so a gets inverted
    assign a_in = (op == VALU_SUB) ? ~op_a : op_a;

    ////////////////////////////////////////////////////
    // byte-sliced adder
    ////////////////////////////////////////////////////

    always_comb begin : addsub
        logic       carry;
        logic [8:0] part;
        carry = 1'b0;
        for (int i = 0; i < 4; i++) begin
            if (elem_start[i]) begin
                carry = (op == VALU_SUB);  // +1 of the two's complement
            end
            part = {1'b0, op_b[8*i +: 8]} + {1'b0, a_in[8*i +: 8]} + {8'd0, carry};
            sum[8*i +: 8] = part[7:0];
            carry = part[8];               // dropped at the next element start
        end
    end

    always_comb begin
        case (op)
            VALU_ADD,
            VALU_SUB:  result = sum;
            VALU_AND:  result = op_a & op_b;
            VALU_OR:   result = op_a | op_b;
            VALU_XOR:  result = op_a ^ op_b;
            VALU_MOVE: result = op_a;      // splat and store path
            default:   result = '0;
        endcase
    end

endmodule

//--- hw/v_regfile.sv
`timescale 1ns/1ns

module v_regfile #(
    parameter int num_words = 4                     // 32-bit words per register
) (
    input  logic                         clk,
    input  v_isa_pkg::vreg_addr_t        rd_addr_a,
    input  v_isa_pkg::vreg_addr_t        rd_addr_b,
    input  logic                         wr_en,
    input  v_isa_pkg::vreg_addr_t        wr_addr,
    input  logic [num_words*32-1:0]      wr_data,
    output logic [num_words*32-1:0]      rd_data_a,
    output logic [num_words*32-1:0]      rd_data_b
);

    ////////////////////////////////////////////////////
    // storage
    ////////////////////////////////////////////////////

    // v0..v31, whole register per entry
    logic [num_words*32-1:0] regs [32];

    ////////////////////////////////////////////////////
    // ports
    ////////////////////////////////////////////////////

    // reads are combinational, same cycle as the address
    assign rd_data_a = regs[rd_addr_a];   // vs1 or store source
    assign rd_data_b = regs[rd_addr_b];   // vs2

    // single write port, whole register at once
    always_ff @(posedge clk) begin
        if (wr_en) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // a read of the register being written returns the old value
    // the sequencer never reads and writes in the same cycle

endmodule

//--- hw/v_decoder.sv
`timescale 1ns/1ns

module v_decoder (
    input  v_arch_pkg::word_t     instr,
    output logic                  is_vconfig,
    output logic                  is_vstore,
    output logic                  is_valu,
    output v_isa_pkg::valu_op_e   alu_op,
    output v_isa_pkg::src_sel_e   src_a,
    output v_isa_pkg::vreg_addr_t vd,
    output v_isa_pkg::vreg_addr_t vs1,
    output v_isa_pkg::vreg_addr_t vs2,
    output v_isa_pkg::xreg_addr_t rs1,
    output v_isa_pkg::imm5_t      imm,
    output v_arch_pkg::sew_e      new_sew
);

    import v_isa_pkg::*;
    import v_arch_pkg::*;

    opcode_e    opcode;
    funct3_e    funct3;
    logic [5:0] funct6;
    logic       vm;         // 1 = unmasked, the only form we take

    assign opcode = opcode_e'(instr[6:0]);
    assign funct3 = funct3_e'(instr[14:12]);
    assign funct6 = instr[31:26];
    assign vm     = instr[25];

    always_comb begin
        is_vconfig = 1'b0;
        is_vstore  = 1'b0;
        is_valu    = 1'b0;
        alu_op     = VALU_MOVE;
        src_a      = SRC_VREG;
        vd         = instr[11:7];
        vs1        = instr[19:15];
        vs2        = instr[24:20];
        rs1        = instr[19:15];   // shares the vs1 / imm field
        imm        = instr[19:15];
        new_sew    = sew_e'(instr[25:23]);  // zimm[5:3]

        case (opcode)
            OP_V: begin
                if (funct3 == OPCFG) begin
                    // vsetvli only, and only 8/16/32 bit elements
                    is_vconfig = !instr[31] && (instr[25:23] inside {E8, E16, E32});
                end else if (vm && (funct3 inside {OPIVV, OPIVX, OPIVI})) begin
                    case (funct3)
                        OPIVX:   src_a = SRC_SCALAR;
                        OPIVI:   src_a = SRC_IMM;
                        default: src_a = SRC_VREG;
                    endcase
                    case (funct6)
                        F6_VADD: begin is_valu = 1'b1; alu_op = VALU_ADD; end
                        F6_VSUB: begin is_valu = (funct3 != OPIVI); alu_op = VALU_SUB; end
                        F6_VAND: begin is_valu = 1'b1; alu_op = VALU_AND; end
                        F6_VOR:  begin is_valu = 1'b1; alu_op = VALU_OR; end
                        F6_VXOR: begin is_valu = 1'b1; alu_op = VALU_XOR; end
                        F6_VMV: begin
                            // splat forms only, vs2 must be zero
                            is_valu = (funct3 != OPIVV) && (instr[24:20] == 5'd0);
                            alu_op  = VALU_MOVE;
                        end
                        default: is_valu = 1'b0;
                    endcase
                end
            end
            STORE_FP: begin
                // nf=0 mew=0 mop=00 vm=1 sumop=0, i.e. plain unit stride
                if ((instr[31:25] == 7'b0000001) && (instr[24:20] == 5'd0) &&
                    (instr[14:12] inside {ST_W8, ST_W16, ST_W32})) begin
                    is_vstore = 1'b1;
                    vs1       = instr[11:7];   // vs3 sits in the vd field
                    src_a     = SRC_VREG;
                    alu_op    = VALU_MOVE;     // lanes pass the register through
                end
            end
            default: ;                         // unsupported, retires as a no-op
        endcase
    end

endmodule

//--- hw/v_arch_pkg.sv
package v_arch_pkg;

    ////////////////////////////////////////////////////
    // datapath widths
    ////////////////////////////////////////////////////

    localparam int WORD_BITS = 32;     // one lane, one scalar register
    localparam int DATAMEM_BITS = 16;  // data memory word address

    typedef logic [WORD_BITS-1:0] word_t;
    typedef logic [DATAMEM_BITS-1:0] mem_addr_t;

    ////////////////////////////////////////////////////
    // vtype element width
    ////////////////////////////////////////////////////

    // same codes as vtype.vsew
    typedef enum logic [2:0] {
        E8  = 3'b000,
        E16 = 3'b001,
        E32 = 3'b010
    } sew_e;

    // elements packed in one 32-bit lane word
    //   E8  -> 4
    //   E16 -> 2
    //   E32 -> 1
    // wider codes are rejected by the decoder

endpackage

//--- hw/v_isa_pkg.sv
package v_isa_pkg;

    ////////////////////////////////////////////////////
    // instruction fields of the kept V subset
    ////////////////////////////////////////////////////

    typedef enum logic [6:0] {
        OP_V     = 7'b1010111,  // arithmetic and vsetvli
        STORE_FP = 7'b0100111   // vector stores reuse the fp store opcode
    } opcode_e;

    typedef enum logic [2:0] {
        OPIVV = 3'b000,         // vector-vector
        OPIVI = 3'b011,         // vector-immediate
        OPIVX = 3'b100,         // vector-scalar
        OPCFG = 3'b111          // vset{i}vl{i}
    } funct3_e;

    // funct6 of the integer ops we keep
    localparam logic [5:0] F6_VADD = 6'b000000;
    localparam logic [5:0] F6_VSUB = 6'b000010;  // no .vi form in the spec
    localparam logic [5:0] F6_VAND = 6'b001001;
    localparam logic [5:0] F6_VOR  = 6'b001010;
    localparam logic [5:0] F6_VXOR = 6'b001011;
    localparam logic [5:0] F6_VMV  = 6'b010111;  // vmv.v.x / vmv.v.i with vs2 = 0

    // width field of unit-stride stores
    localparam logic [2:0] ST_W8  = 3'b000;
    localparam logic [2:0] ST_W16 = 3'b101;
    localparam logic [2:0] ST_W32 = 3'b110;

    ////////////////////////////////////////////////////
    // decoded forms
    ////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        VALU_ADD, VALU_SUB, VALU_AND, VALU_OR, VALU_XOR, VALU_MOVE
    } valu_op_e;

    typedef enum logic [1:0] {SRC_VREG, SRC_SCALAR, SRC_IMM} src_sel_e;

    typedef logic [4:0] vreg_addr_t;
    typedef logic [4:0] xreg_addr_t;
    typedef logic [4:0] imm5_t;

endpackage
